// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_host_domain
RTL_TOP   ?= host_domain
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+include
source/host_pkg.sv
source/reg_bus_if.sv
source/lite_cfg_port.sv
source/llc_cfg_regs.sv
source/host_event_unit.sv
source/host_domain.sv
tests/tb_host_domain.sv

// ==== source/host_domain.sv ====
`timescale 1ns/1ps

module host_domain #(
  parameter int unsigned NUM_SYNC_STAGES = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // LLC configuration, AXI-lite slave
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  host_pkg::lite_addr_t  aw_addr_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  host_pkg::lite_data_t  w_data_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic [1:0]            b_resp_o,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  host_pkg::lite_addr_t  ar_addr_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output host_pkg::lite_data_t  r_data_o,
  output logic [1:0]            r_resp_o,
  // LLC events
  input  host_pkg::llc_events_t llc_events_i,
  // Cluster DMA event, four-phase
  input  logic                  dma_pe_evt_valid_i,
  output logic                  dma_pe_evt_ack_o,
  output logic                  dma_pe_evt_o,
  // Regions for the external LLC
  output host_pkg::lite_addr_t  llc_cache_addr_start_o,
  output host_pkg::lite_addr_t  llc_cache_addr_end_o,
  output host_pkg::lite_addr_t  llc_spm_addr_start_o
);

  host_pkg::cnt_array_t           counts;
  logic [host_pkg::NumEvents-1:0] cnt_clear;

  reg_bus_if cfg_bus ();

  lite_cfg_port i_lite_cfg_port (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .aw_valid_i ( aw_valid_i ),
    .aw_ready_o ( aw_ready_o ),
    .aw_addr_i  ( aw_addr_i  ),
    .w_valid_i  ( w_valid_i  ),
    .w_ready_o  ( w_ready_o  ),
    .w_data_i   ( w_data_i   ),
    .b_valid_o  ( b_valid_o  ),
    .b_ready_i  ( b_ready_i  ),
    .b_resp_o   ( b_resp_o   ),
    .ar_valid_i ( ar_valid_i ),
    .ar_ready_o ( ar_ready_o ),
    .ar_addr_i  ( ar_addr_i  ),
    .r_valid_o  ( r_valid_o  ),
    .r_ready_i  ( r_ready_i  ),
    .r_data_o   ( r_data_o   ),
    .r_resp_o   ( r_resp_o   ),
    .bus        ( cfg_bus    )
  );

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i         ( clk_i                  ),
    .rst_n_i       ( rst_n_i                ),
    .bus           ( cfg_bus                ),
    .counts_i      ( counts                 ),
    .cnt_clear_o   ( cnt_clear              ),
    .cache_start_o ( llc_cache_addr_start_o ),
    .cache_end_o   ( llc_cache_addr_end_o   ),
    .spm_start_o   ( llc_spm_addr_start_o   )
  );

  host_event_unit #(
    .NUM_SYNC_STAGES ( NUM_SYNC_STAGES )
  ) i_host_event_unit (
    .clk_i        ( clk_i              ),
    .rst_n_i      ( rst_n_i            ),
    .llc_events_i ( llc_events_i       ),
    .dma_valid_i  ( dma_pe_evt_valid_i ),
    .dma_ack_o    ( dma_pe_evt_ack_o   ),
    .dma_evt_o    ( dma_pe_evt_o       ),
    .cnt_clear_i  ( cnt_clear          ),
    .counts_o     ( counts             )
  );

endmodule

// ==== source/host_event_unit.sv ====
`timescale 1ns/1ps

module host_event_unit #(
  parameter int unsigned NUM_SYNC_STAGES = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  host_pkg::llc_events_t          llc_events_i,
  input  logic                           dma_valid_i,
  output logic                           dma_ack_o,
  output logic                           dma_evt_o,
  input  logic [host_pkg::NumEvents-1:0] cnt_clear_i,
  output host_pkg::cnt_array_t           counts_o
);

  logic [NUM_SYNC_STAGES-1:0]     sync_q;
  logic                           ack_prev_q;
  logic                           dma_evt_q;
  logic [host_pkg::NumEvents-1:0] inc;
  host_pkg::cnt_array_t           cnt_q;

  // Cluster valid crosses into this domain here
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= dma_valid_i;
      for (int i = 1; i < NUM_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign dma_ack_o = sync_q[NUM_SYNC_STAGES-1];

  // Rising edge of the synchronized level, one pulse per handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_prev_q <= 1'b0;
      dma_evt_q  <= 1'b0;
    end else begin
      ack_prev_q <= dma_ack_o;
      dma_evt_q  <= dma_ack_o & ~ack_prev_q;
    end
  end

  assign dma_evt_o = dma_evt_q;

  always_comb begin
    inc = '0;
    inc[host_pkg::EvtReadHit]   = llc_events_i.read_hit;
    inc[host_pkg::EvtReadMiss]  = llc_events_i.read_miss;
    inc[host_pkg::EvtWriteHit]  = llc_events_i.write_hit;
    inc[host_pkg::EvtWriteMiss] = llc_events_i.write_miss;
    inc[host_pkg::EvtDma]       = dma_evt_q;
  end

  // Clear beats increment, counters wrap
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < host_pkg::NumEvents; i++) begin
        if (cnt_clear_i[i]) begin
          cnt_q[i] <= '0;
        end else if (inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign counts_o = cnt_q;

endmodule

// ==== source/host_pkg.sv ====
package host_pkg;

  // AXI-lite configuration port
  localparam int unsigned LiteAddrWidth = 32;
  localparam int unsigned LiteDataWidth = 32;

  typedef logic [LiteAddrWidth-1:0] lite_addr_t;
  typedef logic [LiteDataWidth-1:0] lite_data_t;

  // Event counters
  localparam int unsigned CntWidth  = 32;
  localparam int unsigned NumEvents = 5;

  typedef logic [CntWidth-1:0] cnt_t;

  typedef enum logic [2:0] {
    EvtReadHit   = 3'd0,
    EvtReadMiss  = 3'd1,
    EvtWriteHit  = 3'd2,
    EvtWriteMiss = 3'd3,
    EvtDma       = 3'd4
  } evt_idx_e;

  typedef cnt_t [NumEvents-1:0] cnt_array_t;

  // One-cycle flags from the LLC
  typedef struct packed {
    logic read_hit;
    logic read_miss;
    logic write_hit;
    logic write_miss;
  } llc_events_t;

  // Register byte offsets
  localparam lite_addr_t RegCacheStart = 32'h0000_0000;
  localparam lite_addr_t RegCacheEnd   = 32'h0000_0004;
  localparam lite_addr_t RegSpmStart   = 32'h0000_0008;
  localparam lite_addr_t RegCntClear   = 32'h0000_000C;
  localparam lite_addr_t RegCntBase    = 32'h0000_0010;

  localparam lite_data_t UnmappedData = 32'hDEAD_F000;

  localparam logic [1:0] RespOkay = 2'b00;

endpackage

// ==== source/lite_cfg_port.sv ====
`timescale 1ns/1ps

module lite_cfg_port (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Write address and data
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  host_pkg::lite_addr_t aw_addr_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  host_pkg::lite_data_t w_data_i,
  // Write response
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  output logic [1:0]           b_resp_o,
  // Read address
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  host_pkg::lite_addr_t ar_addr_i,
  // Read data
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output host_pkg::lite_data_t r_data_o,
  output logic [1:0]           r_resp_o,
  reg_bus_if.port              bus
);

  logic                 b_valid_q;
  logic                 r_valid_q;
  host_pkg::lite_data_t r_data_q;
  logic                 wr_accept;
  logic                 rd_ready;
  logic                 rd_accept;

  // Address and data are taken together, only with no B outstanding
  assign wr_accept = aw_valid_i & w_valid_i & ~b_valid_q;

  // Writes win over a read in the same cycle
  assign rd_ready  = ~r_valid_q & ~wr_accept;
  assign rd_accept = ar_valid_i & rd_ready;

  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign ar_ready_o = rd_ready;

  assign bus.req   = wr_accept | rd_accept;
  assign bus.we    = wr_accept;
  assign bus.addr  = wr_accept ? aw_addr_i : ar_addr_i;
  assign bus.wdata = w_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_accept) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Hold read data until the R beat is taken
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= bus.rdata;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = host_pkg::RespOkay;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = host_pkg::RespOkay;

endmodule

// ==== source/llc_cfg_regs.sv ====
`timescale 1ns/1ps

module llc_cfg_regs (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  reg_bus_if.regs                         bus,
  input  host_pkg::cnt_array_t            counts_i,
  output logic [host_pkg::NumEvents-1:0]  cnt_clear_o,
  output host_pkg::lite_addr_t            cache_start_o,
  output host_pkg::lite_addr_t            cache_end_o,
  output host_pkg::lite_addr_t            spm_start_o
);

  localparam int unsigned IdxWidth = $clog2(host_pkg::NumEvents);

  host_pkg::lite_addr_t cache_start_q;
  host_pkg::lite_addr_t cache_end_q;
  host_pkg::lite_addr_t spm_start_q;
  logic                 wr_en;
  host_pkg::lite_addr_t cnt_offset;
  logic                 cnt_hit;
  logic [IdxWidth-1:0]  cnt_idx;

  assign wr_en = bus.req & bus.we;

  // LLC region registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
    end else if (wr_en) begin
      case (bus.addr)
        host_pkg::RegCacheStart: cache_start_q <= host_pkg::lite_addr_t'(bus.wdata);
        host_pkg::RegCacheEnd:   cache_end_q   <= host_pkg::lite_addr_t'(bus.wdata);
        host_pkg::RegSpmStart:   spm_start_q   <= host_pkg::lite_addr_t'(bus.wdata);
        default: begin
        end
      endcase
    end
  end

  // Clear mask reaches the counters in the write cycle
  always_comb begin
    cnt_clear_o = '0;
    if (wr_en && bus.addr == host_pkg::RegCntClear) begin
      cnt_clear_o = bus.wdata[host_pkg::NumEvents-1:0];
    end
  end

  // Counter window starts at RegCntBase, one word per event
  assign cnt_offset = bus.addr - host_pkg::RegCntBase;
  assign cnt_hit    = (cnt_offset[1:0] == 2'b00) &&
                      (cnt_offset < host_pkg::lite_addr_t'(4 * host_pkg::NumEvents));
  assign cnt_idx    = cnt_offset[IdxWidth+1:2];

  always_comb begin
    bus.rdata = host_pkg::UnmappedData;
    case (bus.addr)
      host_pkg::RegCacheStart: bus.rdata = host_pkg::lite_data_t'(cache_start_q);
      host_pkg::RegCacheEnd:   bus.rdata = host_pkg::lite_data_t'(cache_end_q);
      host_pkg::RegSpmStart:   bus.rdata = host_pkg::lite_data_t'(spm_start_q);
      host_pkg::RegCntClear:   bus.rdata = '0;
      default: begin
        if (cnt_hit) begin
          bus.rdata = host_pkg::lite_data_t'(counts_i[cnt_idx]);
        end
      end
    endcase
  end

  assign cache_start_o = cache_start_q;
  assign cache_end_o   = cache_end_q;
  assign spm_start_o   = spm_start_q;

endmodule

// ==== source/reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if;

  logic                 req;
  logic                 we;
  host_pkg::lite_addr_t addr;
  host_pkg::lite_data_t wdata;
  host_pkg::lite_data_t rdata;

  // Access side, one strobe per access
  modport port (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  // Register side, rdata is answered in the strobe cycle
  modport regs (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// ==== include/tb_lite_tasks.svh ====
`ifndef TB_LITE_TASKS_SVH
`define TB_LITE_TASKS_SVH

// Tasks start and return 1 ns after a rising clock edge

task automatic write_req(input host_pkg::lite_addr_t addr, input host_pkg::lite_data_t data);
  int unsigned cycles;
  bit          accepted;
  cycles     = 0;
  accepted   = 1'b0;
  aw_valid_i = 1'b1;
  aw_addr_i  = addr;
  w_valid_i  = 1'b1;
  w_data_i   = data;
  while (!accepted && cycles < WaitLimit) begin
    @(negedge clk_i);
    accepted = aw_ready_o && w_ready_o;
    @(posedge clk_i);
    #1;
    cycles++;
  end
  aw_valid_i = 1'b0;
  w_valid_i  = 1'b0;
  if (accepted) begin
    model_write(addr, data);
  end else begin
    $display("Timeout at %0t: write to 0x%08h was never accepted", $time, addr);
    fail_count++;
  end
endtask

task automatic read_req(input host_pkg::lite_addr_t addr);
  int unsigned cycles;
  bit          accepted;
  cycles     = 0;
  accepted   = 1'b0;
  ar_valid_i = 1'b1;
  ar_addr_i  = addr;
  while (!accepted && cycles < WaitLimit) begin
    @(negedge clk_i);
    if (ar_ready_o) begin
      accepted = 1'b1;
      // Expected value as of the accept cycle
      exp_q.push_back(ref_read(addr));
      addr_q.push_back(addr);
    end
    @(posedge clk_i);
    #1;
    cycles++;
  end
  ar_valid_i = 1'b0;
  if (!accepted) begin
    $display("Timeout at %0t: read of 0x%08h was never accepted", $time, addr);
    fail_count++;
  end
endtask

// Four-phase handshake, valid held until ack, then ack must fall
task automatic dma_handshake();
  int unsigned cycles;
  bit          ack_seen;
  cycles             = 0;
  ack_seen           = 1'b0;
  dma_pe_evt_valid_i = 1'b1;
  while (!ack_seen && cycles < WaitLimit) begin
    @(negedge clk_i);
    ack_seen = dma_pe_evt_ack_o;
    @(posedge clk_i);
    #1;
    cycles++;
  end
  dma_pe_evt_valid_i = 1'b0;
  if (!ack_seen) begin
    $display("Timeout at %0t: DMA ack never rose", $time);
    fail_count++;
    return;
  end
  dma_count++;
  shadow_cnt[host_pkg::EvtDma]++;
  cycles = 0;
  while (ack_seen && cycles < WaitLimit) begin
    @(negedge clk_i);
    ack_seen = dma_pe_evt_ack_o;
    @(posedge clk_i);
    #1;
    cycles++;
  end
  if (ack_seen) begin
    $display("Timeout at %0t: DMA ack never fell", $time);
    fail_count++;
  end
endtask

`endif

// ==== tests/tb_host_domain.sv ====
`timescale 1ns/1ps

module tb_host_domain;

  localparam int unsigned SyncStages    = 2;
  localparam int unsigned WaitLimit     = 40;
  localparam int unsigned EventCycles   = 250;
  localparam int unsigned DmaHandshakes = 9;
  localparam logic [31:0] Seed          = 32'hb845e1d7;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  aw_valid_i;
  logic                  aw_ready_o;
  host_pkg::lite_addr_t  aw_addr_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  host_pkg::lite_data_t  w_data_i;
  logic                  b_valid_o;
  logic                  b_ready_i;
  logic [1:0]            b_resp_o;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  host_pkg::lite_addr_t  ar_addr_i;
  logic                  r_valid_o;
  logic                  r_ready_i;
  host_pkg::lite_data_t  r_data_o;
  logic [1:0]            r_resp_o;
  host_pkg::llc_events_t llc_events_i;
  logic                  dma_pe_evt_valid_i;
  logic                  dma_pe_evt_ack_o;
  logic                  dma_pe_evt_o;
  host_pkg::lite_addr_t  llc_cache_addr_start_o;
  host_pkg::lite_addr_t  llc_cache_addr_end_o;
  host_pkg::lite_addr_t  llc_spm_addr_start_o;

  // Reference model state
  host_pkg::lite_addr_t  shadow_cache_start = '0;
  host_pkg::lite_addr_t  shadow_cache_end   = '0;
  host_pkg::lite_addr_t  shadow_spm_start   = '0;
  host_pkg::cnt_t        shadow_cnt [host_pkg::NumEvents] = '{default: '0};
  host_pkg::lite_data_t  exp_q [$];
  host_pkg::lite_addr_t  addr_q [$];
  int unsigned           mismatch_count = 0;
  int unsigned           fail_count     = 0;
  int unsigned           dma_count      = 0;
  int unsigned           ack_rises      = 0;
  int unsigned           evt_pulses     = 0;
  logic                  ack_prev       = 1'b0;

  host_domain #(.NUM_SYNC_STAGES(SyncStages)) dut0 (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  function automatic host_pkg::lite_data_t ref_read(input host_pkg::lite_addr_t addr);
    host_pkg::lite_data_t value;
    value = host_pkg::UnmappedData;
    if (addr == host_pkg::RegCacheStart) value = shadow_cache_start;
    else if (addr == host_pkg::RegCacheEnd) value = shadow_cache_end;
    else if (addr == host_pkg::RegSpmStart) value = shadow_spm_start;
    else if (addr == host_pkg::RegCntClear) value = '0;
    else if (addr >= host_pkg::RegCntBase && addr[1:0] == 2'b00 &&
             addr < host_pkg::RegCntBase + 4 * host_pkg::NumEvents) begin
      value = shadow_cnt[(addr - host_pkg::RegCntBase) / 4];
    end
    return value;
  endfunction

  function automatic void model_write(input host_pkg::lite_addr_t addr,
                                      input host_pkg::lite_data_t data);
    if (addr == host_pkg::RegCacheStart) shadow_cache_start = data;
    else if (addr == host_pkg::RegCacheEnd) shadow_cache_end = data;
    else if (addr == host_pkg::RegSpmStart) shadow_spm_start = data;
    else if (addr == host_pkg::RegCntClear) begin
      for (int k = 0; k < host_pkg::NumEvents; k++) begin
        if (data[k]) shadow_cnt[k] = '0;
      end
    end
  endfunction

  task automatic check_regions();
    if (llc_cache_addr_start_o !== shadow_cache_start ||
        llc_cache_addr_end_o !== shadow_cache_end ||
        llc_spm_addr_start_o !== shadow_spm_start) begin
      $display("Mismatch at %0t: region outputs %08h %08h %08h, expected %08h %08h %08h",
               $time, llc_cache_addr_start_o, llc_cache_addr_end_o, llc_spm_addr_start_o,
               shadow_cache_start, shadow_cache_end, shadow_spm_start);
      mismatch_count++;
    end
  endtask

  `include "tb_lite_tasks.svh"

  // Checks every B and R beat as it is taken
  always @(negedge clk_i) begin : compare_responses
    host_pkg::lite_data_t expected;
    host_pkg::lite_addr_t addr;
    if (b_valid_o && b_ready_i && b_resp_o !== host_pkg::RespOkay) begin
      $display("Mismatch at %0t: B response %0d, expected OKAY", $time, b_resp_o);
      mismatch_count++;
    end
    if (r_valid_o && r_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: read response without a pending read", $time);
        fail_count++;
      end else begin
        expected = exp_q.pop_front();
        addr     = addr_q.pop_front();
        if (r_data_o !== expected) begin
          $display("Mismatch at %0t: read of 0x%08h returned 0x%08h, expected 0x%08h",
                   $time, addr, r_data_o, expected);
          mismatch_count++;
        end
        if (r_resp_o !== host_pkg::RespOkay) begin
          $display("Mismatch at %0t: R response %0d, expected OKAY", $time, r_resp_o);
          mismatch_count++;
        end
      end
    end
  end

  always @(negedge clk_i) begin : dma_monitor
    if (rst_n_i && dma_pe_evt_ack_o && !ack_prev) ack_rises++;
    if (rst_n_i && dma_pe_evt_o) evt_pulses++;
    ack_prev = dma_pe_evt_ack_o;
  end

  initial begin : stimulus
    host_pkg::lite_addr_t addr;
    host_pkg::lite_data_t data;
    int unsigned          cycles;
    void'($urandom(Seed));
    rst_n_i            = 1'b0;
    aw_valid_i         = 1'b0;
    aw_addr_i          = '0;
    w_valid_i          = 1'b0;
    w_data_i           = '0;
    b_ready_i          = 1'b1;
    ar_valid_i         = 1'b0;
    ar_addr_i          = '0;
    r_ready_i          = 1'b1;
    llc_events_i       = '0;
    dma_pe_evt_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Reset values
    check_regions();
    for (int k = 0; k <= 8; k++) read_req(4 * k);

    // Region registers, plus one write to an unmapped word
    repeat (12) begin
      addr = 4 * ($urandom % 3);
      write_req(addr, $urandom);
      check_regions();
      read_req(addr);
    end
    write_req(32'h0000_0030, $urandom);
    check_regions();

    // Clear register and unmapped space
    read_req(host_pkg::RegCntClear);
    read_req(32'h0000_0024);
    read_req(32'h0000_0013);
    read_req(32'h0000_0002);
    repeat (6) read_req(($urandom & 32'hFFFF_FFFC) | 32'h0000_0100);

    // LLC events, then a random clear mask
    repeat (2) begin
      for (int c = 0; c < EventCycles; c++) begin
        data         = $urandom;
        llc_events_i = host_pkg::llc_events_t'(data[3:0]);
        if (llc_events_i.read_hit) shadow_cnt[host_pkg::EvtReadHit]++;
        if (llc_events_i.read_miss) shadow_cnt[host_pkg::EvtReadMiss]++;
        if (llc_events_i.write_hit) shadow_cnt[host_pkg::EvtWriteHit]++;
        if (llc_events_i.write_miss) shadow_cnt[host_pkg::EvtWriteMiss]++;
        @(posedge clk_i);
        #1;
      end
      llc_events_i = '0;
      for (int k = 0; k < host_pkg::NumEvents; k++) read_req(host_pkg::RegCntBase + 4 * k);
      write_req(host_pkg::RegCntClear, $urandom);
      for (int k = 0; k < host_pkg::NumEvents; k++) read_req(host_pkg::RegCntBase + 4 * k);
    end

    // Cluster DMA events
    repeat (DmaHandshakes) dma_handshake();
    read_req(host_pkg::RegCntBase + 4 * host_pkg::EvtDma);

    // B held, a second write must wait
    b_ready_i = 1'b0;
    write_req(host_pkg::RegSpmStart, $urandom);
    data       = $urandom;
    aw_valid_i = 1'b1;
    aw_addr_i  = host_pkg::RegCacheEnd;
    w_valid_i  = 1'b1;
    w_data_i   = data;
    repeat (4) begin
      @(negedge clk_i);
      if (aw_ready_o || w_ready_o || !b_valid_o) begin
        $display("Error at %0t: write accepted or B dropped while B was held", $time);
        fail_count++;
      end
      @(posedge clk_i);
      #1;
    end
    b_ready_i = 1'b1;
    write_req(host_pkg::RegCacheEnd, data);
    check_regions();

    // R held, a second read must wait
    r_ready_i = 1'b0;
    read_req(host_pkg::RegSpmStart);
    ar_valid_i = 1'b1;
    ar_addr_i  = host_pkg::RegCacheEnd;
    repeat (4) begin
      @(negedge clk_i);
      if (ar_ready_o || !r_valid_o) begin
        $display("Error at %0t: read accepted or R dropped while R was held", $time);
        fail_count++;
      end
      @(posedge clk_i);
      #1;
    end
    r_ready_i = 1'b1;
    read_req(host_pkg::RegCacheEnd);

    cycles = 0;
    while (exp_q.size() > 0 && cycles < WaitLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_q.size() > 0) begin
      $display("Error at %0t: %0d reads never returned data", $time, exp_q.size());
      fail_count++;
    end
    if (ack_rises != dma_count || evt_pulses != dma_count) begin
      $display("Mismatch at %0t: %0d acks and %0d DMA pulses for %0d handshakes",
               $time, ack_rises, evt_pulses, dma_count);
      mismatch_count++;
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
